// File: hw/glb_pkg.sv
// global buffer package: sizes, register map and bus/header structs for the tile chain
`default_nettype none

package glb_pkg;

    // chain and bus sizes
    localparam int NUM_TILES       = 4;
    localparam int TILE_ID_WIDTH   = 4;
    localparam int REG_ADDR_WIDTH  = 5;
    localparam int CFG_ADDR_WIDTH  = 11;
    localparam int CFG_DATA_WIDTH  = 32;

    // address fields, bits 1:0 are byte offset and ignored
    localparam int CFG_REG_LSB     = 2;
    localparam int CFG_TILE_LSB    = 7;

    // dma queues
    localparam int QUEUE_DEPTH     = 4;
    localparam int QUEUE_PTR_WIDTH = $clog2(QUEUE_DEPTH);
    localparam int GLB_ADDR_WIDTH  = 16;
    localparam int NUM_WORDS_WIDTH = 12;

    typedef logic [TILE_ID_WIDTH-1:0]  tile_id_t;
    typedef logic [REG_ADDR_WIDTH-1:0] reg_idx_t;

    // register map
    // header pairs: word count first, then {start_addr, valid}
    localparam reg_idx_t REG_TILE_FLAGS  = 5'd0;
    localparam reg_idx_t REG_ST_CTRL     = 5'd1;
    localparam reg_idx_t REG_ST_HDR_BASE = 5'd2;
    localparam reg_idx_t REG_LD_CTRL     = 5'd10;
    localparam reg_idx_t REG_LD_HDR_BASE = 5'd11;

    typedef struct packed {
        logic                      wr_en;
        logic                      rd_en;
        logic [CFG_ADDR_WIDTH-1:0] addr;
        logic [CFG_DATA_WIDTH-1:0] wr_data;
    } cfg_req_t;

    typedef struct packed {
        logic                      rd_data_valid;
        logic [CFG_DATA_WIDTH-1:0] rd_data;
    } cfg_rsp_t;

    typedef struct packed {
        logic                       valid;
        logic [GLB_ADDR_WIDTH-1:0]  start_addr;
        logic [NUM_WORDS_WIDTH-1:0] num_words;
    } dma_header_t;

    typedef struct packed {
        logic                      valid;
        logic [GLB_ADDR_WIDTH-1:0] addr;
    } dma_strobe_t;

    typedef struct packed {
        logic is_start;
        logic is_end;
    } tile_flags_t;

endpackage

`default_nettype wire

// File: hw/glb_tile_cfg.sv
// glb_tile_cfg: tile register bank with id decode, east forwarding and west read return
`default_nettype none

module glb_tile_cfg (
    input  logic                                    clk,
    input  logic                                    reset,
    input  logic [glb_pkg::TILE_ID_WIDTH-1:0]       tile_id,

    // bus, west side faces tile 0
    input  glb_pkg::cfg_req_t                       cfg_west_req,
    output glb_pkg::cfg_rsp_t                       cfg_west_rsp,
    output glb_pkg::cfg_req_t                       cfg_east_req,
    input  glb_pkg::cfg_rsp_t                       cfg_east_rsp,

    output glb_pkg::tile_flags_t                    tile_flags,

    output logic                                    st_on,
    output logic                                    ld_on,
    output glb_pkg::dma_header_t                    st_headers [glb_pkg::QUEUE_DEPTH],
    output glb_pkg::dma_header_t                    ld_headers [glb_pkg::QUEUE_DEPTH],
    input  logic [glb_pkg::QUEUE_DEPTH-1:0]         st_invalidate,
    input  logic [glb_pkg::QUEUE_DEPTH-1:0]         ld_invalidate
);

    // register index of a header word; second picks the {start_addr, valid} half
    function automatic glb_pkg::reg_idx_t hdr_reg(
        input glb_pkg::reg_idx_t base,
        input int unsigned       slot,
        input logic              second
    );
        glb_pkg::reg_idx_t offset;
        offset = glb_pkg::reg_idx_t'(2 * slot);
        return base + offset + glb_pkg::reg_idx_t'(second);
    endfunction

    logic [glb_pkg::TILE_ID_WIDTH-1:0]  req_tile;
    glb_pkg::reg_idx_t                  req_reg;
    logic                               tile_match;
    logic                               wr_hit;
    logic                               rd_hit;
    logic [glb_pkg::CFG_DATA_WIDTH-1:0] wr_data;
    logic [glb_pkg::CFG_DATA_WIDTH-1:0] rd_mux;

    assign req_tile   = cfg_west_req.addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_ID_WIDTH];
    assign req_reg    = cfg_west_req.addr[glb_pkg::CFG_REG_LSB +: glb_pkg::REG_ADDR_WIDTH];
    assign tile_match = (req_tile == tile_id);
    assign wr_hit     = cfg_west_req.wr_en && tile_match;
    assign rd_hit     = cfg_west_req.rd_en && tile_match;
    assign wr_data    = cfg_west_req.wr_data;

    // register writes
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tile_flags <= '0;
            st_on <= 1'b0;
            ld_on <= 1'b0;
            for (int i = 0; i < glb_pkg::QUEUE_DEPTH; i++) begin
                st_headers[i] <= '0;
                ld_headers[i] <= '0;
            end
        end else begin
            // retire pulses go first so a same-cycle write overrides them
            for (int i = 0; i < glb_pkg::QUEUE_DEPTH; i++) begin
                if (st_invalidate[i]) begin
                    st_headers[i].valid <= 1'b0;
                end
                if (ld_invalidate[i]) begin
                    ld_headers[i].valid <= 1'b0;
                end
            end

            if (wr_hit) begin
                case (req_reg)
                    glb_pkg::REG_TILE_FLAGS: begin
                        tile_flags.is_start <= wr_data[0];
                        tile_flags.is_end <= wr_data[1];
                    end
                    glb_pkg::REG_ST_CTRL: st_on <= wr_data[0];
                    glb_pkg::REG_LD_CTRL: ld_on <= wr_data[0];
                    default: ;
                endcase

                for (int i = 0; i < glb_pkg::QUEUE_DEPTH; i++) begin
                    if (req_reg == hdr_reg(glb_pkg::REG_ST_HDR_BASE, i, 1'b0)) begin
                        st_headers[i].num_words <= wr_data[glb_pkg::NUM_WORDS_WIDTH-1:0];
                    end
                    if (req_reg == hdr_reg(glb_pkg::REG_ST_HDR_BASE, i, 1'b1)) begin
                        {st_headers[i].start_addr, st_headers[i].valid}
                            <= wr_data[glb_pkg::GLB_ADDR_WIDTH:0];
                    end
                    if (req_reg == hdr_reg(glb_pkg::REG_LD_HDR_BASE, i, 1'b0)) begin
                        ld_headers[i].num_words <= wr_data[glb_pkg::NUM_WORDS_WIDTH-1:0];
                    end
                    if (req_reg == hdr_reg(glb_pkg::REG_LD_HDR_BASE, i, 1'b1)) begin
                        {ld_headers[i].start_addr, ld_headers[i].valid}
                            <= wr_data[glb_pkg::GLB_ADDR_WIDTH:0];
                    end
                end
            end
        end
    end

    // read mux, unmapped indices fall through as zero
    always_comb begin
        rd_mux = '0;
        case (req_reg)
            glb_pkg::REG_TILE_FLAGS: begin
                rd_mux[0] = tile_flags.is_start;
                rd_mux[1] = tile_flags.is_end;
            end
            glb_pkg::REG_ST_CTRL: rd_mux[0] = st_on;
            glb_pkg::REG_LD_CTRL: rd_mux[0] = ld_on;
            default: ;
        endcase

        for (int i = 0; i < glb_pkg::QUEUE_DEPTH; i++) begin
            if (req_reg == hdr_reg(glb_pkg::REG_ST_HDR_BASE, i, 1'b0)) begin
                rd_mux[glb_pkg::NUM_WORDS_WIDTH-1:0] = st_headers[i].num_words;
            end
            if (req_reg == hdr_reg(glb_pkg::REG_ST_HDR_BASE, i, 1'b1)) begin
                rd_mux[glb_pkg::GLB_ADDR_WIDTH:0] = {st_headers[i].start_addr, st_headers[i].valid};
            end
            if (req_reg == hdr_reg(glb_pkg::REG_LD_HDR_BASE, i, 1'b0)) begin
                rd_mux[glb_pkg::NUM_WORDS_WIDTH-1:0] = ld_headers[i].num_words;
            end
            if (req_reg == hdr_reg(glb_pkg::REG_LD_HDR_BASE, i, 1'b1)) begin
                rd_mux[glb_pkg::GLB_ADDR_WIDTH:0] = {ld_headers[i].start_addr, ld_headers[i].valid};
            end
        end
    end

    // requests for other tiles move one stage east
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_east_req <= '0;
        end else if ((cfg_west_req.wr_en || cfg_west_req.rd_en) && !tile_match) begin
            cfg_east_req <= cfg_west_req;
        end else begin
            cfg_east_req <= '0;
        end
    end

    // responses move one stage west, a local hit takes the slot
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cfg_west_rsp <= '0;
        end else if (rd_hit) begin
            cfg_west_rsp.rd_data_valid <= 1'b1;
            cfg_west_rsp.rd_data <= rd_mux;
        end else begin
            cfg_west_rsp <= cfg_east_rsp;
        end
    end

endmodule

`default_nettype wire

// File: hw/glb_dma_seq.sv
// glb_dma_seq: walks a header queue in ring order, one address strobe per word, then retires
`default_nettype none

module glb_dma_seq (
    input  logic                            clk,
    input  logic                            reset,
    input  logic                            on,
    input  glb_pkg::dma_header_t            headers [glb_pkg::QUEUE_DEPTH],
    output logic [glb_pkg::QUEUE_DEPTH-1:0] invalidate,
    output glb_pkg::dma_strobe_t            strobe
);

    typedef enum logic [1:0] {
        S_IDLE,
        S_RUN,
        S_RETIRE
    } seq_state_t;

    seq_state_t                          state;
    logic [glb_pkg::QUEUE_PTR_WIDTH-1:0] ptr;
    logic [glb_pkg::NUM_WORDS_WIDTH-1:0] words_left;
    logic [glb_pkg::GLB_ADDR_WIDTH-1:0]  word_addr;
    glb_pkg::dma_header_t                cur_hdr;

    assign cur_hdr = headers[ptr];

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= S_IDLE;
            ptr <= '0;
            words_left <= '0;
            word_addr <= '0;
        end else begin
            case (state)
                S_IDLE: begin
                    // on only gates the start of a header
                    if (on && cur_hdr.valid) begin
                        word_addr <= cur_hdr.start_addr;
                        words_left <= cur_hdr.num_words;
                        if (cur_hdr.num_words == '0) begin
                            state <= S_RETIRE;
                        end else begin
                            state <= S_RUN;
                        end
                    end
                end

                S_RUN: begin
                    // address wraps at the top of the buffer
                    word_addr <= word_addr + 1'b1;
                    words_left <= words_left - 1'b1;
                    if (words_left == 1) begin
                        state <= S_RETIRE;
                    end
                end

                S_RETIRE: begin
                    // pointer wraps round the ring
                    ptr <= ptr + 1'b1;
                    state <= S_IDLE;
                end

                default: state <= S_IDLE;
            endcase
        end
    end

    // strobe while running, one-hot retire pulse
    always_comb begin
        strobe.valid = (state == S_RUN);
        strobe.addr = '0;
        if (state == S_RUN) begin
            strobe.addr = word_addr;
        end

        invalidate = '0;
        if (state == S_RETIRE) begin
            invalidate[ptr] = 1'b1;
        end
    end

endmodule

`default_nettype wire

// File: hw/glb_tile.sv
// glb_tile: one buffer tile, register bank feeding its store and load sequencers
`default_nettype none

module glb_tile (
    input  logic                              clk,
    input  logic                              reset,
    input  logic [glb_pkg::TILE_ID_WIDTH-1:0] tile_id,

    input  glb_pkg::cfg_req_t                 cfg_west_req,
    output glb_pkg::cfg_rsp_t                 cfg_west_rsp,
    output glb_pkg::cfg_req_t                 cfg_east_req,
    input  glb_pkg::cfg_rsp_t                 cfg_east_rsp,

    output glb_pkg::tile_flags_t              tile_flags,
    output glb_pkg::dma_strobe_t              st_strobe,
    output glb_pkg::dma_strobe_t              ld_strobe
);

    logic                            st_on;
    logic                            ld_on;
    glb_pkg::dma_header_t            st_headers [glb_pkg::QUEUE_DEPTH];
    glb_pkg::dma_header_t            ld_headers [glb_pkg::QUEUE_DEPTH];
    logic [glb_pkg::QUEUE_DEPTH-1:0] st_invalidate;
    logic [glb_pkg::QUEUE_DEPTH-1:0] ld_invalidate;

    glb_tile_cfg cfg_i (
        .clk           (clk),
        .reset         (reset),
        .tile_id       (tile_id),
        .cfg_west_req  (cfg_west_req),
        .cfg_west_rsp  (cfg_west_rsp),
        .cfg_east_req  (cfg_east_req),
        .cfg_east_rsp  (cfg_east_rsp),
        .tile_flags    (tile_flags),
        .st_on         (st_on),
        .ld_on         (ld_on),
        .st_headers    (st_headers),
        .ld_headers    (ld_headers),
        .st_invalidate (st_invalidate),
        .ld_invalidate (ld_invalidate)
    );

    // store queue
    glb_dma_seq st_seq_i (
        .clk        (clk),
        .reset      (reset),
        .on         (st_on),
        .headers    (st_headers),
        .invalidate (st_invalidate),
        .strobe     (st_strobe)
    );

    // load queue
    glb_dma_seq ld_seq_i (
        .clk        (clk),
        .reset      (reset),
        .on         (ld_on),
        .headers    (ld_headers),
        .invalidate (ld_invalidate),
        .strobe     (ld_strobe)
    );

endmodule

`default_nettype wire

// File: hw/glb_tile_array.sv
// glb_tile_array: row of buffer tiles on one configuration chain, east end closed off
`default_nettype none

module glb_tile_array (
    input  logic                 clk,
    input  logic                 reset,
    input  glb_pkg::cfg_req_t    cfg_req_in,
    output glb_pkg::cfg_rsp_t    cfg_rsp_out,
    output glb_pkg::tile_flags_t tile_flags [glb_pkg::NUM_TILES],
    output glb_pkg::dma_strobe_t st_strobe [glb_pkg::NUM_TILES],
    output glb_pkg::dma_strobe_t ld_strobe [glb_pkg::NUM_TILES]
);

    // link k sits on the west side of tile k
    // link NUM_TILES is past the east end, requests there are dropped
    glb_pkg::cfg_req_t req_link [glb_pkg::NUM_TILES+1];
    glb_pkg::cfg_rsp_t rsp_link [glb_pkg::NUM_TILES+1];

    assign req_link[0] = cfg_req_in;
    assign cfg_rsp_out = rsp_link[0];

    // nothing answers from beyond the last tile
    assign rsp_link[glb_pkg::NUM_TILES] = '0;

    for (genvar i = 0; i < glb_pkg::NUM_TILES; i++) begin : g_tile
        glb_tile tile_i (
            .clk          (clk),
            .reset        (reset),
            .tile_id      (glb_pkg::tile_id_t'(i)),
            .cfg_west_req (req_link[i]),
            .cfg_west_rsp (rsp_link[i]),
            .cfg_east_req (req_link[i+1]),
            .cfg_east_rsp (rsp_link[i+1]),
            .tile_flags   (tile_flags[i]),
            .st_strobe    (st_strobe[i]),
            .ld_strobe    (ld_strobe[i])
        );
    end

endmodule

`default_nettype wire

// File: sim/glb_tile_cfg_assert.sv
// glb_tile_cfg_assert: bus protocol and retire pulse checks for one tile register bank
`default_nettype none

module glb_tile_cfg_assert (
    input logic                              clk,
    input logic                              reset,
    input logic [glb_pkg::TILE_ID_WIDTH-1:0] tile_id,
    input glb_pkg::cfg_req_t                 cfg_west_req,
    input glb_pkg::cfg_rsp_t                 cfg_west_rsp,
    input glb_pkg::cfg_req_t                 cfg_east_req,
    input glb_pkg::cfg_rsp_t                 cfg_east_rsp,
    input logic [glb_pkg::QUEUE_DEPTH-1:0]   st_invalidate,
    input logic [glb_pkg::QUEUE_DEPTH-1:0]   ld_invalidate
);

    timeunit 1ns;
    timeprecision 1ps;

    logic west_rd_hit;

    assign west_rd_hit = cfg_west_req.rd_en &&
        (cfg_west_req.addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_ID_WIDTH] == tile_id);

    east_not_own_id: assert property (@(posedge clk) disable iff (reset)
        (cfg_east_req.wr_en || cfg_east_req.rd_en)
        |-> (cfg_east_req.addr[glb_pkg::CFG_TILE_LSB +: glb_pkg::TILE_ID_WIDTH] != tile_id))
        else $error("request forwarded east carries this tile's id");

    // a response needs a local read hit or an east response one cycle before
    rsp_has_cause: assert property (@(posedge clk) disable iff (reset)
        $rose(cfg_west_rsp.rd_data_valid) |-> $past(west_rd_hit || cfg_east_rsp.rd_data_valid))
        else $error("west response appeared without a read or east response");

    st_one_retire: assert property (@(posedge clk) disable iff (reset) $onehot0(st_invalidate))
        else $error("more than one store invalidate bit set");

    ld_one_retire: assert property (@(posedge clk) disable iff (reset) $onehot0(ld_invalidate))
        else $error("more than one load invalidate bit set");

endmodule

`default_nettype wire

// File: sim/glb_tile_array_tb.sv
// tile array testbench driving random configuration traffic and checking dma strobes against a model
`default_nettype none

module glb_tile_array_tb;

    timeunit 1ns;
    timeprecision 1ps;

    localparam int READ_TIMEOUT  = 4 * glb_pkg::NUM_TILES;
    localparam int DRAIN_TIMEOUT = 20000;
    // retire tail after the last strobe plus travel time of the on flags
    localparam int SETTLE_CYCLES = 2 * glb_pkg::QUEUE_DEPTH + 2 * glb_pkg::NUM_TILES;
    localparam int NUM_ROUNDS    = 4;

    logic                 clk;
    logic                 reset;
    glb_pkg::cfg_req_t    cfg_req_in;
    glb_pkg::cfg_rsp_t    cfg_rsp_out;
    glb_pkg::tile_flags_t tile_flags [glb_pkg::NUM_TILES];
    glb_pkg::dma_strobe_t st_strobe [glb_pkg::NUM_TILES];
    glb_pkg::dma_strobe_t ld_strobe [glb_pkg::NUM_TILES];

    // model state with store as queue 0 and load as queue 1
    logic [31:0]          img [glb_pkg::NUM_TILES][32];
    int                   ptr [glb_pkg::NUM_TILES][2];
    glb_pkg::dma_strobe_t exp_q [glb_pkg::NUM_TILES][2][$];
    int                   errors;
    int                   timeouts;
    integer               seed;

    glb_tile_array dut_i (
        .clk         (clk),
        .reset       (reset),
        .cfg_req_in  (cfg_req_in),
        .cfg_rsp_out (cfg_rsp_out),
        .tile_flags  (tile_flags),
        .st_strobe   (st_strobe),
        .ld_strobe   (ld_strobe)
    );

    bind glb_tile_cfg glb_tile_cfg_assert cfg_assert_i (.*);

    always #4 clk = ~clk;

    function automatic int hdr_base(input int q);
        return (q == 0) ? int'(glb_pkg::REG_ST_HDR_BASE) : int'(glb_pkg::REG_LD_HDR_BASE);
    endfunction

    // mask of writable register bits
    function automatic logic [31:0] reg_mask(input int idx);
        int rel;
        rel = -1;
        if (idx == int'(glb_pkg::REG_TILE_FLAGS)) return 32'h3;
        if (idx == int'(glb_pkg::REG_ST_CTRL) || idx == int'(glb_pkg::REG_LD_CTRL)) return 32'h1;
        for (int q = 0; q < 2; q++) begin
            if (idx >= hdr_base(q) && idx < hdr_base(q) + 2 * glb_pkg::QUEUE_DEPTH) begin
                rel = idx - hdr_base(q);
            end
        end
        if (rel < 0) return 32'h0;
        return (rel % 2 == 0) ? 32'h0000_0fff : 32'h0001_ffff;
    endfunction

    function automatic int pending();
        int n;
        n = 0;
        for (int k = 0; k < glb_pkg::NUM_TILES; k++) begin
            n += exp_q[k][0].size() + exp_q[k][1].size();
        end
        return n;
    endfunction

    task automatic check_rsp(input glb_pkg::cfg_rsp_t got, input glb_pkg::cfg_rsp_t exp,
                             input int k, input int idx);
        if (got !== exp) begin
            $display("[ERROR] %0t: read of tile %0d register %0d gave %h, expected %h",
                     $time, k, idx, got, exp);
            errors++;
        end
    endtask

    task automatic check_strobe(input glb_pkg::dma_strobe_t got,
                                input glb_pkg::dma_strobe_t exp, input int k, input int q);
        if (got !== exp) begin
            $display("[ERROR] %0t: tile %0d queue %0d strobe %h, expected %h",
                     $time, k, q, got, exp);
            errors++;
        end
    endtask

    task automatic check_flags(input glb_pkg::tile_flags_t got,
                               input glb_pkg::tile_flags_t exp, input int k);
        if (got !== exp) begin
            $display("[ERROR] %0t: tile %0d flags %b, expected %b", $time, k, got, exp);
            errors++;
        end
    endtask

    // one-cycle request strobe driven just after the edge
    task automatic send_req(input glb_pkg::cfg_req_t req);
        @(posedge clk);
        #1;
        cfg_req_in = req;
        @(posedge clk);
        #1;
        cfg_req_in = '0;
    endtask

    task automatic write_reg(input int k, input int idx, input logic [31:0] data);
        glb_pkg::cfg_req_t req;
        req = '0;
        req.wr_en = 1'b1;
        req.addr = {glb_pkg::tile_id_t'(k), glb_pkg::reg_idx_t'(idx), 2'($random(seed))};
        req.wr_data = data;
        if (k < glb_pkg::NUM_TILES) img[k][idx] = data & reg_mask(idx);
        send_req(req);
    endtask

    task automatic read_check(input int k, input int idx);
        glb_pkg::cfg_req_t req;
        glb_pkg::cfg_rsp_t exp;
        int                lat;
        req = '0;
        req.rd_en = 1'b1;
        req.addr = {glb_pkg::tile_id_t'(k), glb_pkg::reg_idx_t'(idx), 2'b00};
        exp.rd_data_valid = 1'b1;
        exp.rd_data = img[k][idx];
        send_req(req);
        lat = 1;
        while (!cfg_rsp_out.rd_data_valid && lat < READ_TIMEOUT) begin
            @(posedge clk);
            #1;
            lat++;
        end
        if (!cfg_rsp_out.rd_data_valid) begin
            $display("%0t: no response came back for tile %0d register %0d", $time, k, idx);
            timeouts++;
        end else begin
            if (lat != 2 * k + 1) begin
                $display("[ERROR] %0t: tile %0d answered after %0d cycles, expected %0d",
                         $time, k, lat, 2 * k + 1);
                errors++;
            end
            check_rsp(cfg_rsp_out, exp, k, idx);
        end
    endtask

    task automatic check_all();
        glb_pkg::tile_flags_t fl;
        for (int k = 0; k < glb_pkg::NUM_TILES; k++) begin
            for (int idx = 0; idx < 32; idx++) read_check(k, idx);
            fl.is_start = img[k][0][0];
            fl.is_end = img[k][0][1];
            check_flags(tile_flags[k], fl, k);
        end
    endtask

    task automatic load_header(input int k, input int q, input int slot);
        logic [31:0] cnt;
        logic [31:0] second;
        cnt = $random(seed);
        // short word counts keep the run brief
        cnt[11:4] = '0;
        second = $random(seed);
        second[0] = (($random(seed) & 3) != 0);
        if (($random(seed) & 3) == 0) second[16:1] = 16'hfffa;
        write_reg(k, hdr_base(q) + 2 * slot, cnt);
        write_reg(k, hdr_base(q) + 2 * slot + 1, second);
    endtask

    // walk the ring from the model pointer until an invalid slot
    task automatic model_queue(input int k, input int q);
        int                   hi;
        int                   n;
        logic [15:0]          a;
        logic                 stall;
        glb_pkg::dma_strobe_t s;
        stall = 1'b0;
        for (int i = 0; i < glb_pkg::QUEUE_DEPTH; i++) begin
            hi = hdr_base(q) + 2 * ptr[k][q] + 1;
            if (!img[k][hi][0]) stall = 1'b1;
            if (!stall) begin
                n = int'(img[k][hi - 1][11:0]);
                a = img[k][hi][16:1];
                for (int w = 0; w < n; w++) begin
                    s.valid = 1'b1;
                    s.addr = a;
                    exp_q[k][q].push_back(s);
                    a = a + 16'd1;
                end
                img[k][hi][0] = 1'b0;
                ptr[k][q] = (ptr[k][q] + 1) % glb_pkg::QUEUE_DEPTH;
            end
        end
    endtask

    task automatic wait_drain();
        int n;
        n = 0;
        while (pending() != 0 && n < DRAIN_TIMEOUT) begin
            @(posedge clk);
            #1;
            n++;
        end
        if (pending() != 0) begin
            $display("%0t: %0d expected strobes never arrived", $time, pending());
            timeouts++;
        end
        repeat (SETTLE_CYCLES) @(posedge clk);
    endtask

    task automatic watch_strobe(input int k, input int q, input glb_pkg::dma_strobe_t s);
        glb_pkg::dma_strobe_t idle;
        idle = '0;
        if (s.valid) begin
            if (exp_q[k][q].size() == 0) begin
                $display("[ERROR] %0t: tile %0d queue %0d strobe at %h with none expected",
                         $time, k, q, s.addr);
                errors++;
            end else begin
                check_strobe(s, exp_q[k][q].pop_front(), k, q);
            end
        end else begin
            // an idle strobe carries no address
            check_strobe(s, idle, k, q);
        end
    endtask

    always @(negedge clk) begin
        if (!reset) begin
            for (int k = 0; k < glb_pkg::NUM_TILES; k++) begin
                watch_strobe(k, 0, st_strobe[k]);
                watch_strobe(k, 1, ld_strobe[k]);
            end
        end
    end

    initial begin
        int          k;
        int          idx;
        logic [31:0] data;
        seed = 32'h1df;
        errors = 0;
        timeouts = 0;
        clk = 1'b0;
        reset = 1'b1;
        cfg_req_in = '0;
        for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
            for (int r = 0; r < 32; r++) img[t][r] = '0;
            ptr[t][0] = 0;
            ptr[t][1] = 0;
        end
        repeat (16) @(posedge clk);
        #1;
        reset = 1'b0;

        // random writes with both queues off and some aimed past the chain at tile 9
        for (int i = 0; i < 48; i++) begin
            k = $random(seed) & 3;
            if (($random(seed) & 7) == 0) k = 9;
            idx = $random(seed) & 31;
            data = $random(seed);
            if (idx == int'(glb_pkg::REG_ST_CTRL) || idx == int'(glb_pkg::REG_LD_CTRL)) begin
                data[0] = 1'b0;
            end
            write_reg(k, idx, data);
        end
        check_all();

        for (int round = 0; round < NUM_ROUNDS; round++) begin
            for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
                write_reg(t, int'(glb_pkg::REG_TILE_FLAGS), $random(seed));
                for (int q = 0; q < 2; q++) begin
                    for (int s = 0; s < glb_pkg::QUEUE_DEPTH; s++) load_header(t, q, s);
                    model_queue(t, q);
                end
            end
            for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
                write_reg(t, int'(glb_pkg::REG_ST_CTRL), 32'h1);
                write_reg(t, int'(glb_pkg::REG_LD_CTRL), 32'h1);
            end
            wait_drain();
            for (int t = 0; t < glb_pkg::NUM_TILES; t++) begin
                write_reg(t, int'(glb_pkg::REG_ST_CTRL), 32'h0);
                write_reg(t, int'(glb_pkg::REG_LD_CTRL), 32'h0);
            end
            check_all();
        end

        $display("errors: %0d, timeouts: %0d", errors, timeouts);
        if (errors == 0 && timeouts == 0) begin
            $display("*** PASSED ***");
        end else begin
            $display("*** FAILED ***");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: glb_tile_array.f
hw/glb_pkg.sv
hw/glb_tile_cfg.sv
hw/glb_dma_seq.sv
hw/glb_tile.sv
hw/glb_tile_array.sv
sim/glb_tile_cfg_assert.sv
sim/glb_tile_array_tb.sv

// File: run_sim.sh
#!/bin/sh
# build and run the tile array testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
BIN=glb_tile_array_sim

verilator --binary --assert -Wno-fatal --top-module glb_tile_array_tb \
    -f glb_tile_array.f -Mdir obj_dir -o "$BIN"
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/"$BIN" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -qF '*** PASSED ***' "$LOG"; then
    echo "simulation result: pass"
    exit 0
fi
echo "simulation result: fail"
exit 1
